// File: include/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32

// Top address bits that pick a region
`define SEL_W 2

// Byte address widths of the on-chip memories
`define BOOT_ADDR_W 10
`define RAM_ADDR_W 12

// Clocks per bit after reset
`define UART_DIV_INIT 16

`endif

// File: hw/soc_pkg.sv
`include "soc_defines.svh"

package soc_pkg;

   // One code per value of the region select bits
   typedef enum logic [`SEL_W-1:0] {
      BOOT       = 2'd0,
      UART       = 2'd1,
      SOFT_RESET = 2'd2,
      RAM        = 2'd3
   } target_e;

   // UART register word index, addr[4:2]
   typedef enum logic [2:0] {
      TX_DATA  = 3'd0,
      TX_BUSY  = 3'd1,
      RX_DATA  = 3'd2,
      RX_VALID = 3'd3,
      DIV      = 3'd4
   } uart_reg_e;

   typedef enum logic [1:0] {
      TXS_IDLE,
      TXS_START,
      TXS_DATA,
      TXS_STOP
   } uart_tx_state_e;

   typedef enum logic [1:0] {
      RXS_IDLE,
      RXS_START,
      RXS_DATA,
      RXS_STOP
   } uart_rx_state_e;

endpackage

// File: hw/mem_bus_if.sv
`include "soc_defines.svh"

interface mem_bus_if;
   logic              valid;
   logic [`ADDR_W-1:0] addr;
   logic [`DATA_W-1:0] wdata;
   // Zero strobe means read
   logic [3:0]        wstrb;
   logic [`DATA_W-1:0] rdata;
   logic              ready;

   modport master (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );
endinterface

// File: hw/bus_interconnect.sv
`include "soc_defines.svh"

module bus_interconnect (
   input logic       boot,
   mem_bus_if.slave  cpu,
   mem_bus_if.master boot_mem,
   mem_bus_if.master uart,
   mem_bus_if.master rst,
   mem_bus_if.master ram
);
   import soc_pkg::*;

   target_e region;
   target_e sel;

   assign region = target_e'(cpu.addr[`ADDR_W-1 -: `SEL_W]);

   // After the first soft reset the low region goes to main RAM
   always_comb begin
      if (!boot && region == BOOT)
         sel = RAM;
      else
         sel = region;
   end

   assign boot_mem.addr  = cpu.addr;
   assign boot_mem.wdata = cpu.wdata;
   assign boot_mem.wstrb = cpu.wstrb;
   assign uart.addr      = cpu.addr;
   assign uart.wdata     = cpu.wdata;
   assign uart.wstrb     = cpu.wstrb;
   assign rst.addr       = cpu.addr;
   assign rst.wdata      = cpu.wdata;
   assign rst.wstrb      = cpu.wstrb;
   assign ram.addr       = cpu.addr;
   assign ram.wdata      = cpu.wdata;
   assign ram.wstrb      = cpu.wstrb;

   assign boot_mem.valid = cpu.valid && sel == BOOT;
   assign uart.valid     = cpu.valid && sel == UART;
   assign rst.valid      = cpu.valid && sel == SOFT_RESET;
   assign ram.valid      = cpu.valid && sel == RAM;

   always_comb begin
      case (sel)
         BOOT: begin
            cpu.rdata = boot_mem.rdata;
            cpu.ready = boot_mem.ready;
         end
         UART: begin
            cpu.rdata = uart.rdata;
            cpu.ready = uart.ready;
         end
         SOFT_RESET: begin
            cpu.rdata = rst.rdata;
            cpu.ready = rst.ready;
         end
         default: begin
            cpu.rdata = ram.rdata;
            cpu.ready = ram.ready;
         end
      endcase
   end

endmodule

// File: hw/word_ram.sv
`include "soc_defines.svh"

module word_ram #(
   parameter int ADDR_W = 8
) (
   input logic      clk,
   input logic      reset,
   mem_bus_if.slave bus
);

   logic [`DATA_W-1:0] mem [2**ADDR_W];
   logic [ADDR_W-1:0]  word_addr;
   logic               access;

   assign word_addr = bus.addr[ADDR_W+1:2];

   // First cycle of a request only
   assign access = bus.valid && !bus.ready;

   always_ff @(posedge clk) begin
      if (access) begin
         for (int i = 0; i < `DATA_W/8; i++) begin
            if (bus.wstrb[i])
               mem[word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
         end
         bus.rdata <= mem[word_addr];
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         bus.ready <= 1'b0;
      else
         bus.ready <= access;
   end

endmodule

// File: hw/uart_core.sv
`include "soc_defines.svh"

module uart_core (
   input  logic     clk,
   input  logic     reset,
   mem_bus_if.slave bus,
   output logic     txd,
   input  logic     rxd,
   output logic     rts,
   input  logic     cts
);
   import soc_pkg::*;

   uart_reg_e      reg_idx;
   logic           access;
   logic           wr;
   logic [15:0]    div;
   logic [7:0]     tx_hold;
   logic           tx_pending;
   logic           tx_start;
   logic           tx_busy;
   uart_tx_state_e tx_state;
   logic [15:0]    tx_cnt;
   logic [2:0]     tx_bit;
   logic [7:0]     tx_shift;
   logic [1:0]     rx_sync;
   logic           rx_in;
   uart_rx_state_e rx_state;
   logic [15:0]    rx_cnt;
   logic [2:0]     rx_bit;
   logic [7:0]     rx_shift;
   logic           rx_done;
   logic [7:0]     rx_data;
   logic           rx_valid;

   assign reg_idx  = uart_reg_e'(bus.addr[4:2]);
   assign access   = bus.valid && !bus.ready;
   assign wr       = bus.wstrb != 4'b0;
   assign tx_start = tx_state == TXS_IDLE && tx_pending && cts;
   assign tx_busy  = tx_pending || tx_state != TXS_IDLE;
   assign rx_in    = rx_sync[1];
   assign rx_done  = rx_state == RXS_STOP && rx_cnt == div - 16'd1 && rx_in;
   assign rts      = !rx_valid;

   // Register access
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bus.ready  <= 1'b0;
         div        <= 16'(`UART_DIV_INIT);
         tx_pending <= 1'b0;
         rx_valid   <= 1'b0;
      end else begin
         bus.ready <= access;
         if (access && wr && reg_idx == DIV)
            div <= bus.wdata[15:0];
         if (access && wr && reg_idx == TX_DATA)
            tx_pending <= 1'b1;
         else if (tx_start)
            tx_pending <= 1'b0;
         if (rx_done)
            rx_valid <= 1'b1;
         else if (access && !wr && reg_idx == RX_DATA)
            rx_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (access && wr && reg_idx == TX_DATA)
         tx_hold <= bus.wdata[7:0];
      if (rx_done)
         rx_data <= rx_shift;
      if (access) begin
         case (reg_idx)
            TX_BUSY:  bus.rdata <= `DATA_W'(tx_busy);
            RX_DATA:  bus.rdata <= `DATA_W'(rx_data);
            RX_VALID: bus.rdata <= `DATA_W'(rx_valid);
            DIV:      bus.rdata <= `DATA_W'(div);
            default:  bus.rdata <= '0;
         endcase
      end
   end

   // Transmitter
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_state <= TXS_IDLE;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         tx_shift <= '0;
         txd      <= 1'b1;
      end else begin
         case (tx_state)
            TXS_IDLE: begin
               txd <= 1'b1;
               if (tx_start) begin
                  tx_shift <= tx_hold;
                  tx_cnt   <= '0;
                  txd      <= 1'b0;
                  tx_state <= TXS_START;
               end
            end
            TXS_START: begin
               if (tx_cnt == div - 16'd1) begin
                  tx_cnt   <= '0;
                  tx_bit   <= '0;
                  txd      <= tx_shift[0];
                  tx_state <= TXS_DATA;
               end else begin
                  tx_cnt <= tx_cnt + 16'd1;
               end
            end
            TXS_DATA: begin
               if (tx_cnt == div - 16'd1) begin
                  tx_cnt <= '0;
                  if (tx_bit == 3'd7) begin
                     txd      <= 1'b1;
                     tx_state <= TXS_STOP;
                  end else begin
                     tx_bit   <= tx_bit + 3'd1;
                     tx_shift <= tx_shift >> 1;
                     txd      <= tx_shift[1];
                  end
               end else begin
                  tx_cnt <= tx_cnt + 16'd1;
               end
            end
            default: begin
               if (tx_cnt == div - 16'd1)
                  tx_state <= TXS_IDLE;
               else
                  tx_cnt <= tx_cnt + 16'd1;
            end
         endcase
      end
   end

   // Receiver samples each bit in its middle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rx_sync  <= 2'b11;
         rx_state <= RXS_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_shift <= '0;
      end else begin
         rx_sync <= {rx_sync[0], rxd};
         case (rx_state)
            RXS_IDLE: begin
               rx_cnt <= '0;
               if (!rx_in)
                  rx_state <= RXS_START;
            end
            RXS_START: begin
               if (rx_cnt == (div >> 1) - 16'd1) begin
                  rx_cnt   <= '0;
                  rx_bit   <= '0;
                  // Glitch shorter than half a bit is ignored
                  rx_state <= rx_in ? RXS_IDLE : RXS_DATA;
               end else begin
                  rx_cnt <= rx_cnt + 16'd1;
               end
            end
            RXS_DATA: begin
               if (rx_cnt == div - 16'd1) begin
                  rx_cnt   <= '0;
                  rx_shift <= {rx_in, rx_shift[7:1]};
                  rx_bit   <= rx_bit + 3'd1;
                  if (rx_bit == 3'd7)
                     rx_state <= RXS_STOP;
               end else begin
                  rx_cnt <= rx_cnt + 16'd1;
               end
            end
            default: begin
               if (rx_cnt == div - 16'd1)
                  rx_state <= RXS_IDLE;
               else
                  rx_cnt <= rx_cnt + 16'd1;
            end
         endcase
      end
   end

endmodule

// File: hw/reset_ctrl.sv
module reset_ctrl (
   input  logic     clk,
   input  logic     reset,
   mem_bus_if.slave bus,
   output logic     boot,
   output logic     master_reset
);

   logic access;
   logic soft_reset;

   assign access = bus.valid && !bus.ready;

   // Any write restarts the master and leaves boot mode for good
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bus.ready  <= 1'b0;
         soft_reset <= 1'b0;
         boot       <= 1'b1;
      end else begin
         bus.ready  <= access;
         soft_reset <= access && bus.wstrb != 4'b0;
         if (access && bus.wstrb != 4'b0)
            boot <= 1'b0;
      end
   end

   assign bus.rdata    = '0;
   assign master_reset = reset | soft_reset;

endmodule

// File: hw/soc_system.sv
`include "soc_defines.svh"

module soc_system (
   input  logic               clk,
   input  logic               reset,
   input  logic               m_valid,
   input  logic [`ADDR_W-1:0] m_addr,
   input  logic [`DATA_W-1:0] m_wdata,
   input  logic [3:0]         m_wstrb,
   output logic [`DATA_W-1:0] m_rdata,
   output logic               m_ready,
   output logic               master_reset,
   output logic               uart_txd,
   input  logic               uart_rxd,
   output logic               uart_rts,
   input  logic               uart_cts
);

   logic boot;

   mem_bus_if cpu_bus ();
   mem_bus_if boot_bus ();
   mem_bus_if uart_bus ();
   mem_bus_if rst_bus ();
   mem_bus_if ram_bus ();

   // Processor port
   assign cpu_bus.valid = m_valid;
   assign cpu_bus.addr  = m_addr;
   assign cpu_bus.wdata = m_wdata;
   assign cpu_bus.wstrb = m_wstrb;
   assign m_rdata       = cpu_bus.rdata;
   assign m_ready       = cpu_bus.ready;

   bus_interconnect i_bus_interconnect (
      .boot     (boot),
      .cpu      (cpu_bus.slave),
      .boot_mem (boot_bus.master),
      .uart     (uart_bus.master),
      .rst      (rst_bus.master),
      .ram      (ram_bus.master)
   );

   word_ram #(
      .ADDR_W (`BOOT_ADDR_W - 2)
   ) boot_ram (
      .clk   (clk),
      .reset (reset),
      .bus   (boot_bus.slave)
   );

   word_ram #(
      .ADDR_W (`RAM_ADDR_W - 2)
   ) main_ram (
      .clk   (clk),
      .reset (reset),
      .bus   (ram_bus.slave)
   );

   uart_core i_uart_core (
      .clk   (clk),
      .reset (reset),
      .bus   (uart_bus.slave),
      .txd   (uart_txd),
      .rxd   (uart_rxd),
      .rts   (uart_rts),
      .cts   (uart_cts)
   );

   reset_ctrl i_reset_ctrl (
      .clk          (clk),
      .reset        (reset),
      .bus          (rst_bus.slave),
      .boot         (boot),
      .master_reset (master_reset)
   );

endmodule

// File: tests/tb_soc.sv
`include "soc_defines.svh"

module tb_soc;
   timeunit 1ns;
   timeprecision 1ps;
   import soc_pkg::*;

   localparam int BUS_TIMEOUT   = 20;
   localparam int POLL_TIMEOUT  = 1000;
   localparam int DRAIN_TIMEOUT = 10;
   localparam logic [15:0] BIT_CLKS = 16'd12;

   logic               clk;
   logic               reset;
   logic               m_valid;
   logic [`ADDR_W-1:0] m_addr;
   logic [`DATA_W-1:0] m_wdata;
   logic [3:0]         m_wstrb;
   logic [`DATA_W-1:0] m_rdata;
   logic               m_ready;
   logic               master_reset;
   logic               uart_txd;
   logic               uart_rxd;
   logic               uart_rts;
   logic               uart_cts;

   integer             seed;
   int                 errors;
   int                 checks;
   int                 tests;
   int                 test_base;
   string              test_name;
   int                 mr_cycles;
   logic               model_boot;
   logic [`DATA_W-1:0] boot_model [int];
   logic [`DATA_W-1:0] ram_model [int];
   logic [`DATA_W-1:0] exp_q [$];
   logic [`DATA_W-1:0] got_q [$];
   string              what_q [$];

   soc_system i_soc_system (
      .clk          (clk),
      .reset        (reset),
      .m_valid      (m_valid),
      .m_addr       (m_addr),
      .m_wdata      (m_wdata),
      .m_wstrb      (m_wstrb),
      .m_rdata      (m_rdata),
      .m_ready      (m_ready),
      .master_reset (master_reset),
      .uart_txd     (uart_txd),
      .uart_rxd     (uart_rxd),
      .uart_rts     (uart_rts),
      .uart_cts     (uart_cts)
   );

   // Serial loopback
   assign uart_rxd = uart_txd;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(negedge clk) begin
      if (!reset && master_reset)
         mr_cycles++;
   end

   // Checks every read result queued by the bus tasks
   always @(posedge clk) begin
      logic [`DATA_W-1:0] exp_w;
      logic [`DATA_W-1:0] got_w;
      string              what;
      while (exp_q.size() != 0) begin
         exp_w = exp_q.pop_front();
         got_w = got_q.pop_front();
         what  = what_q.pop_front();
         checks++;
         assert (got_w === exp_w) else begin
            errors++;
            $display("ERROR %0t ns: %s read %h, expected %h", $time, what, got_w, exp_w);
         end
      end
   end

   // Applies the access to the memory model and returns the old word
   function automatic logic [`DATA_W-1:0] model_access(input logic [`ADDR_W-1:0] addr,
                                                       input logic [`DATA_W-1:0] wdata,
                                                       input logic [3:0] wstrb);
      target_e            region;
      logic               to_boot;
      int                 idx;
      int                 i;
      logic [`DATA_W-1:0] old_word;
      logic [`DATA_W-1:0] new_word;
      region  = target_e'(addr[`ADDR_W-1 -: `SEL_W]);
      to_boot = region == BOOT && model_boot;
      if (to_boot) begin
         idx      = int'(addr[`BOOT_ADDR_W-1:2]);
         old_word = boot_model.exists(idx) ? boot_model[idx] : 'x;
      end else begin
         idx      = int'(addr[`RAM_ADDR_W-1:2]);
         old_word = ram_model.exists(idx) ? ram_model[idx] : 'x;
      end
      new_word = old_word;
      for (i = 0; i < 4; i++) begin
         if (wstrb[i])
            new_word[8*i +: 8] = wdata[8*i +: 8];
      end
      if (wstrb != 4'b0) begin
         if (to_boot)
            boot_model[idx] = new_word;
         else
            ram_model[idx] = new_word;
      end
      return old_word;
   endfunction

   function automatic logic [`ADDR_W-1:0] make_addr(input target_e t,
                                                    input logic [`ADDR_W-1:0] offs);
      return {t, offs[`ADDR_W-`SEL_W-1:0]};
   endfunction

   task automatic stop_on_timeout(input string what);
      $display("Timeout at %0t ns: %s", $time, what);
      $display("*** FAILED ***");
      $finish;
   endtask

   task automatic bus_transfer(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] wdata,
                               input logic [3:0] wstrb, output logic [`DATA_W-1:0] rdata);
      int cycles;
      cycles = 0;
      @(posedge clk);
      m_valid <= 1'b1;
      m_addr  <= addr;
      m_wdata <= wdata;
      m_wstrb <= wstrb;
      do begin
         if (cycles == BUS_TIMEOUT)
            stop_on_timeout($sformatf("no ready for access to %h", addr));
         @(negedge clk);
         cycles++;
      end while (m_ready !== 1'b1);
      rdata = m_rdata;
      // Valid cycle plus the ready cycle
      checks++;
      assert (cycles == 2) else begin
         errors++;
         $display("ERROR %0t ns: ready after %0d cycles at %h, expected 2", $time, cycles, addr);
      end
      @(posedge clk);
      m_valid <= 1'b0;
      m_wstrb <= 4'b0;
   endtask

   task automatic expect_read(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
                              input string what);
      got_q.push_back(got);
      exp_q.push_back(exp);
      what_q.push_back(what);
   endtask

   task automatic mem_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data,
                            input logic [3:0] strb);
      logic [`DATA_W-1:0] rd;
      void'(model_access(addr, data, strb));
      bus_transfer(addr, data, strb, rd);
   endtask

   task automatic mem_read(input logic [`ADDR_W-1:0] addr);
      logic [`DATA_W-1:0] exp;
      logic [`DATA_W-1:0] rd;
      exp = model_access(addr, '0, 4'b0);
      bus_transfer(addr, '0, 4'b0, rd);
      expect_read(rd, exp, $sformatf("memory at %h", addr));
   endtask

   task automatic uart_write(input uart_reg_e r, input logic [`DATA_W-1:0] data);
      logic [`DATA_W-1:0] rd;
      bus_transfer(make_addr(UART, 32'(r) << 2), data, 4'hf, rd);
   endtask

   task automatic uart_read_check(input uart_reg_e r, input logic [`DATA_W-1:0] exp,
                                  input string what);
      logic [`DATA_W-1:0] rd;
      bus_transfer(make_addr(UART, 32'(r) << 2), '0, 4'b0, rd);
      expect_read(rd, exp, what);
   endtask

   task automatic wait_rx_valid();
      logic [`DATA_W-1:0] rd;
      int                 polls;
      polls = 0;
      rd    = '0;
      while (rd[0] !== 1'b1) begin
         if (polls == POLL_TIMEOUT)
            stop_on_timeout("UART receiver never reported a byte");
         bus_transfer(make_addr(UART, 32'(RX_VALID) << 2), '0, 4'b0, rd);
         polls++;
      end
   endtask

   task automatic drain_compares();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == DRAIN_TIMEOUT)
            stop_on_timeout("read results were never compared");
         @(negedge clk);
         waited++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_base = errors;
   endtask

   task automatic end_test();
      drain_compares();
      tests++;
      if (errors == test_base)
         $display("Test %0d %s: ok", tests, test_name);
      else
         $display("Test %0d %s: %0d errors", tests, test_name, errors - test_base);
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   initial begin
      logic [`ADDR_W-1:0] addrs [64];
      logic [3:0]         strb;
      logic [7:0]         sent;
      logic [`DATA_W-1:0] rd;
      int                 i;
      int                 txd_low;
      seed       = 96882;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      mr_cycles  = 0;
      model_boot = 1'b1;
      reset      = 1'b1;
      m_valid    = 1'b0;
      m_addr     = '0;
      m_wdata    = '0;
      m_wstrb    = 4'b0;
      uart_cts   = 1'b1;
      repeat (16) @(posedge clk);
      reset <= 1'b0;

      start_test("main RAM");
      for (i = 0; i < 64; i++) begin
         addrs[i] = make_addr(RAM, $random(seed) & 32'hffc);
         strb     = 4'($random(seed));
         if (strb == 4'b0)
            strb = 4'hf;
         mem_write(addrs[i], $random(seed), strb);
      end
      for (i = 0; i < 64; i++)
         mem_read(addrs[i]);
      end_test();

      start_test("boot remap");
      mem_write(make_addr(BOOT, 32'h40), 32'hb007_0040, 4'hf);
      mem_write(make_addr(RAM, 32'h40), 32'h3a30_0040, 4'hf);
      mem_read(make_addr(BOOT, 32'h40));
      mem_read(make_addr(RAM, 32'h40));
      end_test();

      start_test("soft reset");
      mr_cycles = 0;
      bus_transfer(make_addr(SOFT_RESET, 32'h0), 32'h1, 4'hf, rd);
      model_boot = 1'b0;
      repeat (4) @(negedge clk);
      checks++;
      assert (mr_cycles == 1) else begin
         errors++;
         $display("ERROR %0t ns: master_reset high for %0d cycles, expected 1", $time, mr_cycles);
      end
      mem_read(make_addr(BOOT, 32'h40));
      mem_read(make_addr(BOOT, 32'h1040));
      mem_write(make_addr(BOOT, 32'h2080), 32'h0dd5_2080, 4'hf);
      mem_read(make_addr(RAM, 32'h080));
      // Higher offset bits must not matter in the low region
      for (i = 0; i < 8; i++)
         mem_read({2'b00, 18'($random(seed)), addrs[i][11:0]});
      end_test();

      start_test("UART loopback");
      uart_write(DIV, 32'(BIT_CLKS));
      uart_read_check(DIV, 32'(BIT_CLKS), "DIV readback");
      for (i = 0; i < 8; i++) begin
         sent = 8'($random(seed));
         uart_write(TX_DATA, 32'(sent));
         wait_rx_valid();
         @(negedge clk);
         check_flag(uart_rts, 1'b0, "uart_rts with unread byte");
         uart_read_check(RX_DATA, 32'(sent), $sformatf("RX_DATA for byte %0d", i));
         @(negedge clk);
         check_flag(uart_rts, 1'b1, "uart_rts after RX_DATA read");
      end
      end_test();

      start_test("flow control");
      @(posedge clk);
      uart_cts <= 1'b0;
      sent = 8'($random(seed));
      uart_write(TX_DATA, 32'(sent));
      uart_read_check(TX_BUSY, 32'h1, "TX_BUSY with cts low");
      txd_low = 0;
      repeat (200) begin
         @(negedge clk);
         if (uart_txd !== 1'b1)
            txd_low++;
      end
      checks++;
      assert (txd_low == 0) else begin
         errors++;
         $display("ERROR %0t ns: uart_txd low for %0d cycles with cts low", $time, txd_low);
      end
      @(posedge clk);
      uart_cts <= 1'b1;
      wait_rx_valid();
      uart_read_check(RX_DATA, 32'(sent), "RX_DATA after cts raised");
      end_test();

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: all.f
+incdir+include
hw/soc_pkg.sv
hw/mem_bus_if.sv
hw/bus_interconnect.sv
hw/word_ram.sv
hw/uart_core.sv
hw/reset_ctrl.sv
hw/soc_system.sv
tests/tb_soc.sv
